//--- ics_periph.f
hw/ics_periph_pkg.sv
hw/periph_bus.sv
hw/periph_regs.sv
hw/pad_shifter.sv
hw/dsp_mult.sv
hw/ics_periph.sv
verification/tb_ics_periph.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -Wall -Wno-fatal
TOP       := tb_ics_periph
FILELIST  := ics_periph.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a listed source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- verification/tb_ics_periph.sv
//////////////////////////////
// Peripheral block testbench
// Drives the video clock domain bus and checks LEDs,
// multiplier, gamepad mock and flash pins
//////////////////////////////

`default_nettype none

module tb_ics_periph
    import ics_periph_pkg::*;
();

    localparam int dsp_width = 16;
    localparam int pad_width = 16;
    localparam int prod_width = 2 * dsp_width;
    localparam int ready_latency = 2;
    localparam int ready_timeout = 10;

    logic                  vdp_clk;
    logic                  vdp_reset;
    logic                  mem_valid;
    logic [addr_width-1:0] mem_addr;
    logic [strb_width-1:0] mem_wstrb;
    logic [data_width-1:0] mem_wdata;
    logic [data_width-1:0] mem_rdata;
    logic                  mem_ready;
    logic                  led_r;
    logic                  led_b;
    logic                  btn_1;
    logic                  btn_2;
    logic                  btn_3;
    logic                  flash_clk;
    logic                  flash_csn;
    logic [3:0]            flash_io_out;
    logic [3:0]            flash_io_oe;
    logic [3:0]            flash_io_in;

    ics_periph #(
        .dsp_width(dsp_width),
        .pad_width(pad_width)
    ) DUT (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wstrb(mem_wstrb),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .led_r(led_r),
        .led_b(led_b),
        .btn_1(btn_1),
        .btn_2(btn_2),
        .btn_3(btn_3),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_io_out(flash_io_out),
        .flash_io_oe(flash_io_oe),
        .flash_io_in(flash_io_in)
    );

    always #10 vdp_clk = ~vdp_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Signed product, sign extended before multiplying
    function automatic logic signed [prod_width-1:0] mult_ref(
        input logic signed [dsp_width-1:0] a,
        input logic signed [dsp_width-1:0] b
    );
        return prod_width'(a) * prod_width'(b);
    endfunction

    // Loaded word has btn_2 at bit 0, btn_3 at bit 6, btn_1 at bit 7
    function automatic logic pad_ref(input int shifts, input logic b1, input logic b2,
                                     input logic b3);
        case (shifts)
            0: return b2;
            6: return b3;
            7: return b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // One request, held until ready is seen at a falling edge
    task automatic bus_access(input logic [7:0] addr, input logic [3:0] wstrb,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int edges;
        @(negedge vdp_clk);
        mem_valid = 1'b1;
        mem_addr = addr;
        mem_wstrb = wstrb;
        mem_wdata = wdata;
        edges = 0;
        while (!mem_ready) begin
            @(negedge vdp_clk);
            edges++;
            if (edges > ready_timeout) begin
                $display("timeout: no mem_ready within %0d cycles of a request to 0x%0h",
                         ready_timeout, addr);
                $display("Result: FAILED");
                $fatal(1, "bus timeout");
            end
        end
        // First edge counted is the accepting one
        expect_equal("mem_ready latency", 32'(edges - 1), 32'(ready_latency));
        rdata = mem_rdata;
        mem_valid = 1'b0;
        mem_wstrb = '0;
        mem_wdata = '0;
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] echo;
        bus_access(addr, 4'b1111, data, echo);
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
        bus_access(addr, 4'b0000, 32'd0, data);
    endtask

    task automatic expect_flash_pins(input logic [31:0] ctrl);
        logic active;
        active = ctrl[flash_active_bit];
        expect_equal("flash_io_out", 32'(flash_io_out), active ? 32'(ctrl[3:0]) : 32'd0);
        expect_equal("flash_io_oe", 32'(flash_io_oe), active ? 32'(ctrl[7:4]) : 32'd0);
        expect_equal("flash_clk", 32'(flash_clk), active ? 32'(ctrl[flash_clk_bit]) : 32'd0);
        expect_equal("flash_csn", 32'(flash_csn), active ? 32'(ctrl[flash_csn_bit]) : 32'd1);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] seed;
        logic [31:0] op_a;
        logic [31:0] op_b;
        vdp_clk = 1'b0;
        vdp_reset = 1'b1;
        mem_valid = 1'b0;
        mem_addr = '0;
        mem_wstrb = '0;
        mem_wdata = '0;
        btn_1 = 1'b0;
        btn_2 = 1'b0;
        btn_3 = 1'b0;
        flash_io_in = 4'h0;
        seed = 32'd11;
        repeat (5) @(negedge vdp_clk);
        vdp_reset = 1'b0;

        // Reset state
        expect_equal("mem_ready", 32'(mem_ready), 32'd0);
        expect_equal("led_r", 32'(led_r), 32'd1);
        expect_equal("led_b", 32'(led_b), 32'd0);
        expect_flash_pins(32'd0);

        for (int v = 3; v >= 0; v--) begin
            bus_write(addr_status, 32'(v));
            expect_equal("led_r", 32'(led_r), 32'(v % 2));
            expect_equal("led_b", 32'(led_b), 32'(v / 2));
            bus_read(addr_status, rd);
            expect_equal("status readback", rd, 32'(v));
        end
        bus_read(8'h40, rd);
        expect_equal("unmapped 0x40", rd, 32'd0);
        bus_read(8'hc4, rd);
        expect_equal("unmapped 0xc4", rd, 32'd0);

        for (int i = 0; i < 20; i++) begin
            seed = lcg_next(seed);
            op_a = {16'd0, seed[31:16]};
            seed = lcg_next(seed);
            op_b = {16'd0, seed[31:16]};
            bus_write(addr_dsp, op_a);
            bus_write(addr_dsp + 8'h04, op_b);
            bus_read(addr_dsp, rd);
            expect_equal("dsp product at 0x10", rd, mult_ref(op_a[15:0], op_b[15:0]));
            bus_read(addr_dsp + 8'h04, rd);
            expect_equal("dsp product at 0x14", rd, mult_ref(op_a[15:0], op_b[15:0]));
        end

        // Every button pattern, latched then clocked out
        for (int p = 0; p < 8; p++) begin
            btn_1 = p[0];
            btn_2 = p[1];
            btn_3 = p[2];
            bus_write(addr_pad, 32'd1);
            bus_write(addr_pad, 32'd0);
            for (int k = 0; k < pad_width; k++) begin
                bus_read(addr_pad, rd);
                expect_equal("pad_bit", rd, 32'(pad_ref(k, p[0], p[1], p[2])));
                bus_write(addr_pad, 32'd2);
                bus_write(addr_pad, 32'd0);
            end
        end

        flash_io_in = 4'ha;
        bus_write(addr_flash, 32'h0000_81c5);
        expect_flash_pins(32'h0000_81c5);
        bus_read(addr_flash, rd);
        expect_equal("flash_sampled", rd, 32'h0000_000a);
        bus_write(addr_flash, 32'h0000_823a);
        expect_flash_pins(32'h0000_823a);
        flash_io_in = 4'h6;
        bus_read(addr_flash, rd);
        expect_equal("flash_sampled", rd, 32'h0000_0006);
        // Active bit clear, pins go idle
        bus_write(addr_flash, 32'h0000_03ff);
        expect_flash_pins(32'h0000_03ff);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/ics_periph.sv
//////////////////////////////
// Console peripheral block
// Video clock domain bus with LEDs, multiplier,
// gamepad mock and flash pin control
//////////////////////////////

`default_nettype none

module ics_periph
    import ics_periph_pkg::*;
#(
    parameter int dsp_width = 16,
    parameter int pad_width = 16
) (
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  mem_valid,
    input  logic [addr_width-1:0] mem_addr,
    input  logic [strb_width-1:0] mem_wstrb,
    input  logic [data_width-1:0] mem_wdata,
    output logic [data_width-1:0] mem_rdata,
    output logic                  mem_ready,

    output logic                  led_r,
    output logic                  led_b,

    input  logic                  btn_1,
    input  logic                  btn_2,
    input  logic                  btn_3,

    output logic                  flash_clk,
    output logic                  flash_csn,
    output logic [3:0]            flash_io_out,
    output logic [3:0]            flash_io_oe,
    input  logic [3:0]            flash_io_in
);

    // Write strobes from the bus
    logic status_write;
    logic dsp_a_write;
    logic dsp_b_write;
    logic pad_write;
    logic flash_write;

    // Read sources
    logic [1:0]             status_value;
    logic [2*dsp_width-1:0] dsp_product;
    logic                   pad_bit;
    logic [3:0]             flash_sampled;

    logic pad_latch;
    logic pad_clk;

    periph_bus #(
        .dsp_width(dsp_width)
    ) bus (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wstrb(mem_wstrb),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .status_value(status_value),
        .dsp_product(dsp_product),
        .pad_bit(pad_bit),
        .flash_sampled(flash_sampled),
        .status_write(status_write),
        .dsp_a_write(dsp_a_write),
        .dsp_b_write(dsp_b_write),
        .pad_write(pad_write),
        .flash_write(flash_write)
    );

    periph_regs regs (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .status_write(status_write),
        .pad_write(pad_write),
        .flash_write(flash_write),
        .mem_wdata(mem_wdata),
        .flash_io_in(flash_io_in),
        .status_value(status_value),
        .led_r(led_r),
        .led_b(led_b),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_io_out(flash_io_out),
        .flash_io_oe(flash_io_oe),
        .flash_sampled(flash_sampled)
    );

    pad_shifter #(
        .pad_width(pad_width)
    ) pad (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .btn_1(btn_1),
        .btn_2(btn_2),
        .btn_3(btn_3),
        .pad_bit(pad_bit)
    );

    dsp_mult #(
        .dsp_width(dsp_width)
    ) mult (
        .vdp_clk(vdp_clk),
        .dsp_a_write(dsp_a_write),
        .dsp_b_write(dsp_b_write),
        .mem_wdata(mem_wdata),
        .dsp_product(dsp_product)
    );

endmodule

`default_nettype wire

//--- hw/dsp_mult.sv
//////////////////////////////
// DSP multiplier
// Signed operand registers with a registered product
//////////////////////////////

`default_nettype none

module dsp_mult
    import ics_periph_pkg::*;
#(
    parameter int dsp_width = 16
) (
    input  logic                   vdp_clk,

    input  logic                   dsp_a_write,
    input  logic                   dsp_b_write,
    input  logic [data_width-1:0]  mem_wdata,

    output logic [2*dsp_width-1:0] dsp_product
);

    logic signed [dsp_width-1:0] operand_a;
    logic signed [dsp_width-1:0] operand_b;

    // Separate enables keep the operands in the multiplier's input registers
    always_ff @(posedge vdp_clk) begin
        if (dsp_a_write) begin
            operand_a <= mem_wdata[dsp_width-1:0];
        end

        if (dsp_b_write) begin
            operand_b <= mem_wdata[dsp_width-1:0];
        end
    end

    // Product lags operand updates by one cycle
    always_ff @(posedge vdp_clk) begin
        dsp_product <= operand_a * operand_b;
    end

endmodule

`default_nettype wire

//--- hw/pad_shifter.sv
//////////////////////////////
// Gamepad mock
// Latches three buttons and shifts them out serially
//////////////////////////////

`default_nettype none

module pad_shifter #(
    parameter int pad_width = 16
) (
    input  logic vdp_clk,
    input  logic vdp_reset,

    input  logic pad_latch,
    input  logic pad_clk,
    input  logic btn_1,
    input  logic btn_2,
    input  logic btn_3,

    output logic pad_bit
);

    logic [pad_width-1:0] shift_reg;
    logic [pad_width-1:0] load_value;
    logic pad_clk_prev;

    // Button order matches a real pad's B, right, left positions
    always_comb begin
        load_value = '0;
        load_value[0] = btn_2;
        load_value[6] = btn_3;
        load_value[7] = btn_1;
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            shift_reg <= '0;
            pad_clk_prev <= 1'b0;
        end else begin
            pad_clk_prev <= pad_clk;

            // Shift takes priority over a reload
            if (pad_clk && !pad_clk_prev) begin
                shift_reg <= {1'b0, shift_reg[pad_width-1:1]};
            end else if (pad_latch) begin
                shift_reg <= load_value;
            end
        end
    end

    assign pad_bit = shift_reg[0];

endmodule

`default_nettype wire

//--- hw/periph_regs.sv
//////////////////////////////
// Peripheral registers
// Status LEDs, gamepad control and bit-banged flash
// pins with sampled flash inputs
//////////////////////////////

`default_nettype none

module periph_regs
    import ics_periph_pkg::*;
(
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  status_write,
    input  logic                  pad_write,
    input  logic                  flash_write,
    input  logic [data_width-1:0] mem_wdata,
    input  logic [3:0]            flash_io_in,

    output logic [1:0]            status_value,
    output logic                  led_r,
    output logic                  led_b,

    output logic                  pad_latch,
    output logic                  pad_clk,

    output logic                  flash_clk,
    output logic                  flash_csn,
    output logic [3:0]            flash_io_out,
    output logic [3:0]            flash_io_oe,
    output logic [3:0]            flash_sampled
);

    logic [1:0] status;
    logic [1:0] pad_ctrl;

    logic       flash_active;
    logic [3:0] flash_ctrl_out;
    logic [3:0] flash_ctrl_oe;
    logic       flash_ctrl_clk;
    logic       flash_ctrl_csn;

    // Status LEDs
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= status_reset_value;
        end else if (status_write) begin
            status <= mem_wdata[1:0];
        end
    end

    assign status_value = status;
    assign led_r = status[0];
    assign led_b = status[1];

    // Gamepad control, bit 0 latch and bit 1 clock
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl <= 2'b00;
        end else if (pad_write) begin
            pad_ctrl <= mem_wdata[1:0];
        end
    end

    assign pad_latch = pad_ctrl[0];
    assign pad_clk = pad_ctrl[1];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            flash_active <= 1'b0;
        end else if (flash_write) begin
            flash_active <= mem_wdata[flash_active_bit];
        end
    end

    // Pin fields only matter while software owns the port
    always_ff @(posedge vdp_clk) begin
        if (flash_write) begin
            flash_ctrl_out <= mem_wdata[3:0];
            flash_ctrl_oe <= mem_wdata[7:4];
            flash_ctrl_clk <= mem_wdata[flash_clk_bit];
            flash_ctrl_csn <= mem_wdata[flash_csn_bit];
        end
    end

    // Idle pins: deselected, clock low, bus released
    assign flash_clk = flash_active ? flash_ctrl_clk : 1'b0;
    assign flash_csn = flash_active ? flash_ctrl_csn : 1'b1;
    assign flash_io_out = flash_active ? flash_ctrl_out : 4'b0000;
    assign flash_io_oe = flash_active ? flash_ctrl_oe : 4'b0000;

    always_ff @(posedge vdp_clk) begin
        flash_sampled <= flash_io_in;
    end

endmodule

`default_nettype wire

//--- hw/periph_bus.sv
//////////////////////////////
// Peripheral bus
// Decodes requests, pulses one write strobe per write
// and answers with a registered ready and read data
//////////////////////////////

`default_nettype none

module periph_bus
    import ics_periph_pkg::*;
#(
    parameter int dsp_width = 16
) (
    input  logic                   vdp_clk,
    input  logic                   vdp_reset,

    input  logic                   mem_valid,
    input  logic [addr_width-1:0]  mem_addr,
    input  logic [strb_width-1:0]  mem_wstrb,
    input  logic [data_width-1:0]  mem_wdata,
    output logic [data_width-1:0]  mem_rdata,
    output logic                   mem_ready,

    input  logic [1:0]             status_value,
    input  logic [2*dsp_width-1:0] dsp_product,
    input  logic                   pad_bit,
    input  logic [3:0]             flash_sampled,

    output logic                   status_write,
    output logic                   dsp_a_write,
    output logic                   dsp_b_write,
    output logic                   pad_write,
    output logic                   flash_write
);

    typedef enum logic [1:0] {
        bus_idle,
        bus_decode,
        bus_respond
    } bus_state_t;

    bus_state_t state;
    periph_sel_t decoded_sel;
    periph_sel_t sel_q;
    logic accept;
    logic is_write;
    logic [data_width-1:0] read_value;

    // Master keeps valid high through the ready cycle, so no new accept then
    assign accept = mem_valid && (state == bus_idle) && !mem_ready;
    assign is_write = |mem_wstrb;

    always_comb begin
        case (mem_addr[addr_width-1:4])
            addr_status[addr_width-1:4]: decoded_sel = sel_status;
            addr_dsp[addr_width-1:4]:    decoded_sel = sel_dsp;
            addr_pad[addr_width-1:4]:    decoded_sel = sel_pad;
            addr_flash[addr_width-1:4]:  decoded_sel = sel_flash;
            default:                     decoded_sel = sel_none;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= bus_idle;
            sel_q <= sel_none;
            status_write <= 1'b0;
            dsp_a_write <= 1'b0;
            dsp_b_write <= 1'b0;
            pad_write <= 1'b0;
            flash_write <= 1'b0;
            mem_ready <= 1'b0;
        end else begin
            // Strobes and ready are single cycle pulses
            status_write <= 1'b0;
            dsp_a_write <= 1'b0;
            dsp_b_write <= 1'b0;
            pad_write <= 1'b0;
            flash_write <= 1'b0;
            mem_ready <= 1'b0;

            case (state)
                bus_idle: begin
                    if (accept) begin
                        state <= bus_decode;
                    end
                end
                bus_decode: begin
                    sel_q <= decoded_sel;
                    status_write <= is_write && (decoded_sel == sel_status);
                    dsp_a_write <= is_write && (decoded_sel == sel_dsp) && !mem_addr[2];
                    dsp_b_write <= is_write && (decoded_sel == sel_dsp) && mem_addr[2];
                    pad_write <= is_write && (decoded_sel == sel_pad);
                    flash_write <= is_write && (decoded_sel == sel_flash);
                    state <= bus_respond;
                end
                default: begin
                    mem_ready <= 1'b1;
                    state <= bus_idle;
                end
            endcase
        end
    end

    // Both DSP offsets read back the product
    always_comb begin
        read_value = '0;
        case (sel_q)
            sel_status: read_value[1:0] = status_value;
            sel_dsp:    read_value[2*dsp_width-1:0] = dsp_product;
            sel_pad:    read_value[0] = pad_bit;
            sel_flash:  read_value[3:0] = flash_sampled;
            default:    read_value = '0;
        endcase
    end

    // Read data captured together with ready
    always_ff @(posedge vdp_clk) begin
        if (state == bus_respond) begin
            mem_rdata <= read_value;
        end
    end

endmodule

`default_nettype wire

//--- hw/ics_periph_pkg.sv
//////////////////////////////
// Peripheral bus definitions
// Bus widths, address map and target select encoding
// shared by the video clock domain peripherals
//////////////////////////////

`default_nettype none

package ics_periph_pkg;

    // Bus widths
    localparam int data_width = 32;
    localparam int addr_width = 8;
    localparam int strb_width = 4;

    // Region bases, one region per 16 bytes
    localparam logic [addr_width-1:0] addr_status = 8'h00;
    localparam logic [addr_width-1:0] addr_dsp    = 8'h10;
    localparam logic [addr_width-1:0] addr_pad    = 8'h20;
    localparam logic [addr_width-1:0] addr_flash  = 8'h30;

    // Decoded bus target
    typedef enum logic [2:0] {
        sel_none,
        sel_status,
        sel_dsp,
        sel_pad,
        sel_flash
    } periph_sel_t;

    // Red LED on, blue LED off
    localparam logic [1:0] status_reset_value = 2'b01;

    // Flash control word layout
    // Data out in bits 3..0, output enables in bits 7..4
    localparam int flash_active_bit = 15;
    localparam int flash_clk_bit    = 8;
    localparam int flash_csn_bit    = 9;

endpackage

`default_nettype wire
